// ==== source/video_pkg.sv ====
`default_nettype none

package video_pkg;

	////////////////////////////////////////
	// Widths and types
	////////////////////////////////////////
	typedef logic [10:0] pix_cnt_t;   // Pixel, line and threshold counts
	typedef logic [3:0]  mode_code_t; // Raw switch code
	typedef logic [3:0]  blk_cnt_t;   // Aux blocks still queued

	// Switch codes
	typedef enum logic [3:0] {
		MODE_VGA      = 4'b0000,
		MODE_SVGA     = 4'b0001,
		MODE_HDTV720P = 4'b0010,
		MODE_XGA      = 4'b0011,
		MODE_SXGA     = 4'b1000,
		MODE_CAMERA   = 4'b1001
	} video_mode_e;

	// Counter thresholds for one mode
	typedef struct packed {
		pix_cnt_t hsblnk; // Last active pixel
		pix_cnt_t hssync; // Sync start
		pix_cnt_t hesync; // Sync end
		pix_cnt_t heblnk; // Last count of line
		pix_cnt_t vsblnk;
		pix_cnt_t vssync;
		pix_cnt_t vesync;
		pix_cnt_t veblnk;
		logic     sync_neg; // 1 = negative sync
	} mode_timing_t;

	typedef struct packed {
		pix_cnt_t hcount;
		pix_cnt_t vcount;
		logic     hblnk;
		logic     vblnk;
		logic     hsync_raw; // Before polarity
		logic     vsync_raw;
	} raster_t;

	typedef struct packed {
		logic hsync;
		logic vsync;
		logic de;
	} sync_bus_t;

	////////////////////////////////////////
	// Mode timing constants
	////////////////////////////////////////
	// 640x480
	localparam pix_cnt_t HPIXELS_VGA = 11'd640;
	localparam pix_cnt_t VLINES_VGA  = 11'd480;
	localparam pix_cnt_t HSYNCPW_VGA = 11'd96;
	localparam pix_cnt_t VSYNCPW_VGA = 11'd2;
	localparam pix_cnt_t HFNPRCH_VGA = 11'd16;
	localparam pix_cnt_t VFNPRCH_VGA = 11'd11;
	localparam pix_cnt_t HBKPRCH_VGA = 11'd48;
	localparam pix_cnt_t VBKPRCH_VGA = 11'd31;

	// 800x600
	localparam pix_cnt_t HPIXELS_SVGA = 11'd800;
	localparam pix_cnt_t VLINES_SVGA  = 11'd600;
	localparam pix_cnt_t HSYNCPW_SVGA = 11'd128;
	localparam pix_cnt_t VSYNCPW_SVGA = 11'd4;
	localparam pix_cnt_t HFNPRCH_SVGA = 11'd40;
	localparam pix_cnt_t VFNPRCH_SVGA = 11'd1;
	localparam pix_cnt_t HBKPRCH_SVGA = 11'd88;
	localparam pix_cnt_t VBKPRCH_SVGA = 11'd23;

	// 1280x720
	localparam pix_cnt_t HPIXELS_HDTV720P = 11'd1280;
	localparam pix_cnt_t VLINES_HDTV720P  = 11'd720;
	localparam pix_cnt_t HSYNCPW_HDTV720P = 11'd40;
	localparam pix_cnt_t VSYNCPW_HDTV720P = 11'd5;
	localparam pix_cnt_t HFNPRCH_HDTV720P = 11'd110;
	localparam pix_cnt_t VFNPRCH_HDTV720P = 11'd5;
	localparam pix_cnt_t HBKPRCH_HDTV720P = 11'd220;
	localparam pix_cnt_t VBKPRCH_HDTV720P = 11'd20;

	// 1024x768
	localparam pix_cnt_t HPIXELS_XGA = 11'd1024;
	localparam pix_cnt_t VLINES_XGA  = 11'd768;
	localparam pix_cnt_t HSYNCPW_XGA = 11'd136;
	localparam pix_cnt_t VSYNCPW_XGA = 11'd6;
	localparam pix_cnt_t HFNPRCH_XGA = 11'd24;
	localparam pix_cnt_t VFNPRCH_XGA = 11'd3;
	localparam pix_cnt_t HBKPRCH_XGA = 11'd160;
	localparam pix_cnt_t VBKPRCH_XGA = 11'd29;

	// 1280x1024
	localparam pix_cnt_t HPIXELS_SXGA = 11'd1280;
	localparam pix_cnt_t VLINES_SXGA  = 11'd1024;
	localparam pix_cnt_t HSYNCPW_SXGA = 11'd112;
	localparam pix_cnt_t VSYNCPW_SXGA = 11'd3;
	localparam pix_cnt_t HFNPRCH_SXGA = 11'd48;
	localparam pix_cnt_t VFNPRCH_SXGA = 11'd1;
	localparam pix_cnt_t HBKPRCH_SXGA = 11'd248;
	localparam pix_cnt_t VBKPRCH_SXGA = 11'd38;

	// Camera source, 720 lines with narrower syncs
	localparam pix_cnt_t HPIXELS_CAMERA = 11'd1280;
	localparam pix_cnt_t VLINES_CAMERA  = 11'd720;
	localparam pix_cnt_t HSYNCPW_CAMERA = 11'd39;
	localparam pix_cnt_t VSYNCPW_CAMERA = 11'd4;
	localparam pix_cnt_t HFNPRCH_CAMERA = 11'd110;
	localparam pix_cnt_t VFNPRCH_CAMERA = 11'd4;
	localparam pix_cnt_t HBKPRCH_CAMERA = 11'd220;
	localparam pix_cnt_t VBKPRCH_CAMERA = 11'd22;

endpackage

`default_nettype wire

// ==== source/mode_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module mode_select (
	input  logic                    pclk,
	input  logic                    arst_n,
	input  video_pkg::mode_code_t   sw,      // Raw switches, async
	output video_pkg::mode_timing_t timing,  // Thresholds of current mode
	output logic                    restart  // Raster restart strobe
);
	import video_pkg::*;

	mode_code_t   sw_meta;     // First sync flop
	mode_code_t   sw_sync;     // Second sync flop
	mode_code_t   mode_q;      // Registered mode

	// Thresholds from active size, porches and sync width
	function automatic mode_timing_t build_timing(
		input pix_cnt_t hpix,
		input pix_cnt_t hfp,
		input pix_cnt_t hsw,
		input pix_cnt_t hbp,
		input pix_cnt_t vlin,
		input pix_cnt_t vfp,
		input pix_cnt_t vsw,
		input pix_cnt_t vbp,
		input logic     neg
	);
		mode_timing_t t;
		t.hsblnk   = hpix - 11'd1;
		t.hssync   = t.hsblnk + hfp;
		t.hesync   = t.hssync + hsw;
		t.heblnk   = t.hesync + hbp;
		t.vsblnk   = vlin - 11'd1;
		t.vssync   = t.vsblnk + vfp;
		t.vesync   = t.vssync + vsw;
		t.veblnk   = t.vesync + vbp;
		t.sync_neg = neg;
		return t;
	endfunction

	// Two flops for the switches, then the mode register
	always_ff @(posedge pclk or negedge arst_n) begin
		if (!arst_n) begin
			sw_meta <= '0;
			sw_sync <= '0;
			mode_q  <= MODE_VGA;
			restart <= 1'b1; // Raster held at zero
		end else begin
			sw_meta <= sw;
			sw_sync <= sw_meta;
			mode_q  <= sw_sync;
			restart <= (sw_sync != mode_q); // High the cycle new mode shows
		end
	end

	// Table lookup
	always_comb begin
		case (mode_q)
			MODE_VGA:      timing = build_timing(HPIXELS_VGA, HFNPRCH_VGA, HSYNCPW_VGA,
				HBKPRCH_VGA, VLINES_VGA, VFNPRCH_VGA, VSYNCPW_VGA, VBKPRCH_VGA, 1'b1);
			MODE_SVGA:     timing = build_timing(HPIXELS_SVGA, HFNPRCH_SVGA, HSYNCPW_SVGA,
				HBKPRCH_SVGA, VLINES_SVGA, VFNPRCH_SVGA, VSYNCPW_SVGA, VBKPRCH_SVGA, 1'b0);
			MODE_XGA:      timing = build_timing(HPIXELS_XGA, HFNPRCH_XGA, HSYNCPW_XGA,
				HBKPRCH_XGA, VLINES_XGA, VFNPRCH_XGA, VSYNCPW_XGA, VBKPRCH_XGA, 1'b1);
			MODE_SXGA:     timing = build_timing(HPIXELS_SXGA, HFNPRCH_SXGA, HSYNCPW_SXGA,
				HBKPRCH_SXGA, VLINES_SXGA, VFNPRCH_SXGA, VSYNCPW_SXGA, VBKPRCH_SXGA, 1'b0);
			MODE_CAMERA:   timing = build_timing(HPIXELS_CAMERA, HFNPRCH_CAMERA,
				HSYNCPW_CAMERA, HBKPRCH_CAMERA, VLINES_CAMERA, VFNPRCH_CAMERA,
				VSYNCPW_CAMERA, VBKPRCH_CAMERA, 1'b0);
			// 720p, also for unlisted codes
			default:       timing = build_timing(HPIXELS_HDTV720P, HFNPRCH_HDTV720P,
				HSYNCPW_HDTV720P, HBKPRCH_HDTV720P, VLINES_HDTV720P, VFNPRCH_HDTV720P,
				VSYNCPW_HDTV720P, VBKPRCH_HDTV720P, 1'b0);
		endcase
	end

endmodule

`default_nettype wire

// ==== source/raster_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module raster_timing (
	input  logic                    pclk,
	input  logic                    arst_n,
	input  logic                    restart, // Back to pixel 0, line 0
	input  video_pkg::mode_timing_t timing,
	output video_pkg::raster_t      raster
);
	import video_pkg::*;

	pix_cnt_t hcount;    // Pixel within line
	pix_cnt_t vcount;    // Line within frame
	logic     line_end;  // Last count of line
	logic     frame_end; // Last line of frame
	logic     hblnk;
	logic     vblnk;
	logic     hsync_raw;
	logic     vsync_raw;

	// Compare with >= so a smaller new mode cannot overrun
	assign line_end  = (hcount >= timing.heblnk);
	assign frame_end = (vcount >= timing.veblnk);

	////////////////////////////////////////
	// Counters
	////////////////////////////////////////
	always_ff @(posedge pclk or negedge arst_n) begin
		if (!arst_n) begin
			hcount <= '0;
		end else if (restart) begin
			hcount <= '0;
		end else if (line_end) begin
			hcount <= '0; // Wrap
		end else begin
			hcount <= hcount + 11'd1;
		end
	end

	// Line counter steps on the pixel wrap
	always_ff @(posedge pclk or negedge arst_n) begin
		if (!arst_n) begin
			vcount <= '0;
		end else if (restart) begin
			vcount <= '0;
		end else if (line_end) begin
			if (frame_end) begin
				vcount <= '0;
			end else begin
				vcount <= vcount + 11'd1;
			end
		end
	end

	////////////////////////////////////////
	// Flags
	////////////////////////////////////////
	always_comb begin
		hblnk     = (hcount > timing.hsblnk);
		vblnk     = (vcount > timing.vsblnk);
		// Sync between start and end thresholds
		hsync_raw = (hcount > timing.hssync) && (hcount <= timing.hesync);
		vsync_raw = (vcount > timing.vssync) && (vcount <= timing.vesync);
	end

	// Pack for the downstream blocks
	assign raster.hcount    = hcount;
	assign raster.vcount    = vcount;
	assign raster.hblnk     = hblnk;
	assign raster.vblnk     = vblnk;
	assign raster.hsync_raw = hsync_raw;
	assign raster.vsync_raw = vsync_raw;

endmodule

`default_nettype wire

// ==== source/sync_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_stage (
	input  logic                 pclk,
	input  logic                 arst_n,
	input  video_pkg::raster_t   raster,
	input  logic                 sync_neg, // 1 = active low syncs
	output video_pkg::sync_bus_t video
);
	import video_pkg::*;

	sync_bus_t stage1; // Active-high syncs and DE
	sync_bus_t stage2; // Lines up with pixel data

	// Two register stages, as in the pixel pipeline
	always_ff @(posedge pclk or negedge arst_n) begin
		if (!arst_n) begin
			stage1 <= '0;
			stage2 <= '0;
		end else begin
			stage1.hsync <= raster.hsync_raw;
			stage1.vsync <= raster.vsync_raw;
			stage1.de    <= !raster.hblnk && !raster.vblnk; // Active area
			stage2       <= stage1;
		end
	end

	// Polarity at the pins, idle level is sync_neg
	assign video.hsync = stage2.hsync ^ sync_neg;
	assign video.vsync = stage2.vsync ^ sync_neg;
	assign video.de    = stage2.de;

endmodule

`default_nettype wire

// ==== source/aux_slot_sched.sv ====
`timescale 1ns/1ps
`default_nettype none

module aux_slot_sched #(
	parameter int unsigned AUX_BURST  = 32, // Reads per burst
	parameter int unsigned AUX_PERIOD = 36  // Burst start to burst start
) (
	input  logic                pclk,
	input  logic                arst_n,
	input  video_pkg::raster_t  raster,
	input  video_pkg::pix_cnt_t hssync,    // Burst start column
	input  logic                de,        // Output DE, 2 cycles late
	input  logic                aux_empty, // Aux FIFO empty flag
	input  video_pkg::blk_cnt_t aux_blocks,
	output logic                aux_rd     // Aux FIFO read strobe
);
	import video_pkg::*;

	localparam int unsigned CNT_W = $clog2(AUX_PERIOD);

	typedef logic [CNT_W-1:0] slot_cnt_t;

	localparam slot_cnt_t BURST_LAST  = slot_cnt_t'(AUX_BURST - 1);
	localparam slot_cnt_t PERIOD_LAST = slot_cnt_t'(AUX_PERIOD - 1);

	logic      frame_start; // First pixel of line 0
	logic      aux_seen;    // Data seen this frame
	logic      audio_on;    // Data seen last frame
	logic      de_seen;     // Video has started
	logic      armed;
	logic      burst_start;
	blk_cnt_t  blocks_q;
	logic      burst_on;    // Inside a run of bursts
	slot_cnt_t slot_cnt;    // Position within period
	logic      rd_strobe;
	logic      rd_strobe_q;

	assign frame_start = (raster.vcount == '0) && (raster.hcount == '0);

	////////////////////////////////////////
	// Audio presence per frame
	////////////////////////////////////////
	always_ff @(posedge pclk or negedge arst_n) begin
		if (!arst_n) begin
			aux_seen <= 1'b0;
			audio_on <= 1'b0;
		end else if (frame_start) begin
			audio_on <= aux_seen | ~aux_empty; // Includes this cycle
			aux_seen <= 1'b0;
		end else if (!aux_empty) begin
			aux_seen <= 1'b1;
		end
	end

	// Arm only in blanking with data waiting
	always_ff @(posedge pclk or negedge arst_n) begin
		if (!arst_n) begin
			de_seen <= 1'b0;
			armed   <= 1'b0;
		end else begin
			de_seen <= de_seen | de; // Sticky
			armed   <= de_seen & ~de & ~aux_empty;
		end
	end

	// Block count sampled a cycle early
	always_ff @(posedge pclk) begin
		blocks_q <= aux_blocks;
	end

	assign burst_start = armed && (raster.hcount == hssync);

	////////////////////////////////////////
	// Burst counter
	////////////////////////////////////////
	always_ff @(posedge pclk or negedge arst_n) begin
		if (!arst_n) begin
			burst_on  <= 1'b0;
			slot_cnt  <= '0;
			rd_strobe <= 1'b0;
		end else if (!raster.hblnk) begin
			// Active part of a line stops any burst
			burst_on  <= 1'b0;
			slot_cnt  <= '0;
			rd_strobe <= 1'b0;
		end else if (burst_start) begin
			burst_on  <= 1'b1;
			slot_cnt  <= '0;
			rd_strobe <= 1'b1;
		end else if (burst_on) begin
			if (slot_cnt == PERIOD_LAST) begin
				slot_cnt <= '0;
				if (blocks_q != '0) begin
					rd_strobe <= 1'b1; // Next block
				end else begin
					rd_strobe <= 1'b0;
					burst_on  <= 1'b0; // Idle until next arm
				end
			end else begin
				slot_cnt <= slot_cnt + 1'b1;
				if (slot_cnt == BURST_LAST) begin
					rd_strobe <= 1'b0; // Gap to end of period
				end
			end
		end
	end

	// One cycle delay before the FIFO
	always_ff @(posedge pclk or negedge arst_n) begin
		if (!arst_n) begin
			rd_strobe_q <= 1'b0;
		end else begin
			rd_strobe_q <= rd_strobe;
		end
	end

	assign aux_rd = rd_strobe_q & audio_on; // No reads in silent frames

endmodule

`default_nettype wire

// ==== source/video_tx_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_tx_top #(
	parameter int unsigned AUX_BURST  = 32, // Reads per burst
	parameter int unsigned AUX_PERIOD = 36  // Cycles per burst slot
) (
	input  logic                  pclk,
	input  logic                  arst_n,
	input  video_pkg::mode_code_t sw,         // Mode switches
	input  logic                  aux_empty,  // From aux FIFO
	input  video_pkg::blk_cnt_t   aux_blocks, // Blocks left in aux FIFO
	output video_pkg::sync_bus_t  video,      // Syncs and DE
	output logic                  aux_rd      // Aux FIFO read
);
	import video_pkg::*;

	mode_timing_t timing;  // Current mode thresholds
	logic         restart;
	raster_t      raster;  // Counters and raw flags

	////////////////////////////////////////
	// Mode and raster
	////////////////////////////////////////
	mode_select u_mode_select (
		.pclk    (pclk),
		.arst_n  (arst_n),
		.sw      (sw),
		.timing  (timing),
		.restart (restart)
	);

	raster_timing u_raster_timing (
		.pclk    (pclk),
		.arst_n  (arst_n),
		.restart (restart),
		.timing  (timing),
		.raster  (raster)
	);

	// Output syncs, 2 cycles behind raster
	sync_stage u_sync_stage (
		.pclk     (pclk),
		.arst_n   (arst_n),
		.raster   (raster),
		.sync_neg (timing.sync_neg),
		.video    (video)
	);

	// Aux reads in horizontal blanking
	aux_slot_sched #(
		.AUX_BURST  (AUX_BURST),
		.AUX_PERIOD (AUX_PERIOD)
	) u_aux_slot_sched (
		.pclk       (pclk),
		.arst_n     (arst_n),
		.raster     (raster),
		.hssync     (timing.hssync),
		.de         (video.de),
		.aux_empty  (aux_empty),
		.aux_blocks (aux_blocks),
		.aux_rd     (aux_rd)
	);

endmodule

`default_nettype wire

// ==== dv/tb_video_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_video_tx;
	import video_pkg::*;

	// One stimulus row and its expected measurements
	typedef struct packed {
		mode_code_t sw;
		int         hpix;        // Active pixels
		int         vlines;      // Active lines
		int         hsw;         // Hsync width, pixels
		int         vsw;         // Vsync width, lines
		int         line_len;    // heblnk + 1
		int         frame_lines; // veblnk + 1, for the timeout
		logic       neg;         // 1 = active low syncs
		logic       aux_low;     // aux_empty held low
		blk_cnt_t   blocks;
	} row_t;

	localparam int NUM_ROWS = 4;
	localparam int PERIOD   = 40;

	logic       pclk;
	logic       arst_n;
	mode_code_t sw;
	logic       aux_empty;
	blk_cnt_t   aux_blocks;
	sync_bus_t  video;
	logic       aux_rd;

	row_t   rows [NUM_ROWS];
	int     errors;
	integer seed;
	longint cycles;
	longint limit;

	video_tx_top uut (
		.pclk       (pclk),
		.arst_n     (arst_n),
		.sw         (sw),
		.aux_empty  (aux_empty),
		.aux_blocks (aux_blocks),
		.video      (video),
		.aux_rd     (aux_rd)
	);

	initial begin
		pclk = 1'b0;
		forever #(PERIOD / 2) pclk = ~pclk;
	end

	// Run limit
	always @(posedge pclk) begin
		cycles <= cycles + 1;
		if (cycles > limit) begin
			$display("Timeout: no result after %0d clock cycles", limit);
			$display("** FAIL **");
			$finish;
		end
	end

	task automatic check_value(input int got, input int exp, input string what);
		assert (got == exp) else begin
			errors++;
			$display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	// Closes the aux_rd runs of one blanking line
	task automatic check_group(input int runs, input int last_run, input blk_cnt_t blocks);
		if (blocks == '0) begin
			check_value(runs, 1, "aux bursts in blanking line");
			check_value(last_run, 32, "aux_rd single burst length");
		end else begin
			assert (runs >= 2) else begin
				errors++;
				$display("FAILED at %0t: only %0d aux bursts with blocks queued", $time, runs);
			end
		end
	endtask

	////////////////////////////////////////
	// One row: switch, sync up, measure a frame
	////////////////////////////////////////
	task automatic run_row(input row_t r);
		logic vs_act;
		logic vs_prev;
		logic hs_act;
		logic hs_prev;
		logic de_prev;
		logic rd_prev;
		logic tracking;  // Aux lines counted after first de
		bit   first_hs;
		bit   changed;      // New switch code
		bit   quiet_before; // No aux data so far
		int   start_run;
		int   de_run;
		int   de_runs;
		int   hs_gap;
		int   hs_width;
		int   vs_width;
		int   vs_edges;
		int   rd_run;
		int   rd_gap;
		int   runs;
		int   groups;
		@(posedge pclk);
		changed    = (sw != r.sw);
		sw         <= r.sw;
		aux_blocks <= r.blocks;
		repeat (6) @(posedge pclk); // Mode latency plus output pipeline
		@(negedge pclk);
		if (changed) begin // Pixel 0 of line 0 shows here
			start_run = 0;
			while (video.de) begin
				start_run++;
				@(negedge pclk);
			end
			check_value(start_run, r.hpix, "de run after restart");
		end
		vs_prev = video.vsync ^ r.neg;
		forever begin // End of a vsync pulse
			@(negedge pclk);
			vs_act = video.vsync ^ r.neg;
			if (vs_prev && !vs_act) break;
			vs_prev = vs_act;
		end
		quiet_before = aux_empty;
		de_prev  = video.de;
		hs_prev  = video.hsync ^ r.neg;
		rd_prev  = aux_rd;
		vs_prev  = 1'b0;
		tracking = 1'b0;
		first_hs = 1'b1;
		de_run   = 0;
		de_runs  = 0;
		hs_gap   = 0;
		hs_width = 0;
		vs_width = 0;
		vs_edges = 0;
		rd_run   = 0;
		rd_gap   = 0;
		runs     = 0;
		groups   = 0;
		@(posedge pclk);
		aux_empty <= !r.aux_low; // Aux data from the back porch on
		forever begin
			@(negedge pclk); // Outputs settled
			hs_act = video.hsync ^ r.neg;
			vs_act = video.vsync ^ r.neg;
			if (video.de) begin // DE run length
				if (!de_prev) de_run = 0;
				de_run++;
			end
			if (de_prev && !video.de) begin
				check_value(de_run, r.hpix, "de run length");
				de_runs++;
			end
			if (hs_act && !hs_prev) begin // Hsync leading edge
				if (!first_hs) check_value(hs_gap, r.line_len, "hsync period");
				first_hs = 1'b0;
				hs_gap   = 0;
				hs_width = 0;
			end
			if (!hs_act && hs_prev && !first_hs) check_value(hs_width, r.hsw, "hsync width");
			hs_gap++;
			if (hs_act) hs_width++;
			if (vs_act) vs_width++;
			if (vs_act && !vs_prev) vs_edges++;
			assert (!(aux_rd && video.de)) else begin
				errors++;
				$display("FAILED at %0t: aux_rd high during active video", $time);
			end
			// Silent row, or rest of a frame after a silent one
			if (!r.aux_low || (quiet_before && !tracking)) begin
				assert (!aux_rd) else begin
					errors++;
					$display("FAILED at %0t: aux_rd high in a silent frame", $time);
				end
			end
			if (video.de && !de_prev) begin // New line, close the last one
				if (tracking && runs > 0) begin
					check_group(runs, rd_run, r.blocks);
					groups++;
				end
				tracking = 1'b1;
				runs     = 0;
			end
			if (tracking && r.aux_low) begin
				if (aux_rd && !rd_prev) begin
					if (runs > 0 && rd_gap < 36) begin // Next burst, same line
						check_value(rd_gap, 4, "aux_rd gap");
						check_value(rd_run, 32, "aux_rd burst length");
					end else if (runs > 0) begin // Long gap, a vblank line ended
						check_group(runs, rd_run, r.blocks);
						groups++;
						runs = 0;
					end
					runs++;
					rd_run = 0;
				end
				if (aux_rd) begin
					rd_run++;
					rd_gap = 0;
				end else begin
					rd_gap++;
				end
			end
			de_prev = video.de;
			hs_prev = hs_act;
			rd_prev = aux_rd;
			if (vs_prev && !vs_act) break; // Next vsync end closes frame
			vs_prev = vs_act;
		end
		check_value(de_runs, r.vlines, "active lines per frame");
		check_value(vs_width, r.vsw * r.line_len, "vsync width in cycles");
		check_value(vs_edges, 1, "vsync pulses per frame");
		if (r.aux_low) begin
			assert (groups >= r.vlines - 1) else begin
				errors++;
				$display("FAILED at %0t: %0d aux lines in frame", $time, groups);
			end
		end
	endtask

	initial begin
		seed   = 32'h4b2c;
		errors = 0;
		cycles = 0;
		rows[0] = '{4'b0000, 640, 480, 96, 2, 800, 524, 1'b1, 1'b0, 4'd0};
		rows[1] = '{4'b0001, 800, 600, 128, 4, 1056, 628, 1'b0, 1'b1, 4'd0};
		rows[2] = '{4'b0010, 1280, 720, 40, 5, 1650, 750, 1'b0, 1'b1, 4'd0};
		rows[3] = '{4'b0111, 1280, 720, 40, 5, 1650, 750, 1'b0, 1'b1, 4'd0};
		rows[2].blocks = 4'({$random(seed)} % 4);
		rows[3].blocks = 4'({$random(seed)} % 4);
		limit = 1000;
		for (int i = 0; i < NUM_ROWS; i++) begin
			limit += 3 * rows[i].line_len * rows[i].frame_lines;
		end
		sw         = 4'b0000;
		aux_empty  = 1'b1;
		aux_blocks = '0;
		arst_n     = 1'b0;
		repeat (3) @(posedge pclk);
		arst_n <= 1'b1;
		for (int i = 0; i < NUM_ROWS; i++) begin
			run_row(rows[i]);
		end
		$display("Checks done, errors: %0d", errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
source/video_pkg.sv
source/mode_select.sv
source/raster_timing.sv
source/sync_stage.sv
source/aux_slot_sched.sv
source/video_tx_top.sv
dv/tb_video_tx.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the video_tx testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
	-f sim.f \
	--top-module tb_video_tx \
	-o tb_video_tx

./obj_dir/tb_video_tx | tee sim.log

if grep -q "\*\* PASS \*\*" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi
